//--- hw/noncomp_lane.sv
`timescale 1ns/10ps

module noncomp_lane #(
  parameter int unsigned NumPipeRegs = 2,
  parameter bit          LaneFp32    = 1'b1
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  noncomp_pkg::lane_op_t  op_i,
  input  logic                   mask_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  output noncomp_pkg::lane_res_t res_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output logic                   busy_o
);

  localparam logic [31:0] QNAN_FP32 = 32'h7fc0_0000;
  localparam logic [15:0] QNAN_FP16 = 16'h7e00;

  logic                   is_fp32;  // binary32 path exists in wide lanes only
  logic [1:0][31:0]       opnd;     // [0] is a, [1] is b
  logic [1:0][30:0]       mag;
  logic [1:0]             sign;
  logic [1:0]             is_nan;
  logic [1:0]             is_snan;
  logic [1:0]             is_zero;
  logic                   both_zero, any_nan, any_snan;
  logic                   mag_lt, mag_eq;
  logic                   op_lt, op_eq, mm_a_lt_b;
  logic                   sgn_inj;
  logic [31:0]            sgnj_res, minmax_res, result;
  logic                   nv;
  noncomp_pkg::lane_res_t res_d;

  assign is_fp32 = LaneFp32 && (op_i.fmt == noncomp_pkg::FMT_FP32);
  assign opnd    = {op_i.b, op_i.a};

  // --------------------------------------------------------------------------
  // Operand classification
  // --------------------------------------------------------------------------
  always_comb begin : classify
    for (int i = 0; i < 2; i++) begin
      if (is_fp32) begin
        sign[i]    = opnd[i][31];
        mag[i]     = opnd[i][30:0];
        is_nan[i]  = (&opnd[i][30:23]) & (|opnd[i][22:0]);
        is_snan[i] = is_nan[i] & ~opnd[i][22];  // Quiet bit clear
      end else begin
        sign[i]    = opnd[i][15];
        mag[i]     = {16'b0, opnd[i][14:0]};
        is_nan[i]  = (&opnd[i][14:10]) & (|opnd[i][9:0]);
        is_snan[i] = is_nan[i] & ~opnd[i][9];
      end
      is_zero[i] = (mag[i] == '0);
    end
  end

  assign both_zero = &is_zero;
  assign any_nan   = |is_nan;
  assign any_snan  = |is_snan;
  assign mag_lt    = mag[0] < mag[1];
  assign mag_eq    = mag[0] == mag[1];

  // Ordering on non-NaN values, signed zeros are equal here
  assign op_eq = both_zero | ((sign[0] == sign[1]) & mag_eq);

  always_comb begin : ordering
    if (both_zero) begin
      op_lt = 1'b0;
    end else if (sign[0] != sign[1]) begin
      op_lt = sign[0];              // Negative side is smaller
    end else if (sign[0]) begin
      op_lt = ~mag_lt & ~mag_eq;    // Both negative, larger magnitude wins
    end else begin
      op_lt = mag_lt;
    end
  end

  // Min/max puts -0 below +0
  assign mm_a_lt_b = both_zero ? (sign[0] & ~sign[1]) : op_lt;

  // --------------------------------------------------------------------------
  // Operation results
  // --------------------------------------------------------------------------
  always_comb begin : sign_inject
    case (op_i.op)
      noncomp_pkg::OP_SGNJN: sgn_inj = ~sign[1];
      noncomp_pkg::OP_SGNJX: sgn_inj = sign[0] ^ sign[1];
      default:               sgn_inj = sign[1];
    endcase
    if (is_fp32) begin
      sgnj_res = {sgn_inj, opnd[0][30:0]};
    end else begin
      sgnj_res = {16'hffff, sgn_inj, opnd[0][14:0]};
    end
  end

  always_comb begin : min_max
    if (is_nan[0] & is_nan[1]) begin
      minmax_res = is_fp32 ? QNAN_FP32 : {16'hffff, QNAN_FP16};
    end else if (is_nan[0]) begin
      minmax_res = opnd[1];
    end else if (is_nan[1]) begin
      minmax_res = opnd[0];
    end else if ((op_i.op == noncomp_pkg::OP_MIN) == mm_a_lt_b) begin
      minmax_res = opnd[0];
    end else begin
      minmax_res = opnd[1];
    end
    if (!is_fp32) begin
      minmax_res[31:16] = '1;  // Box the half result inside the lane
    end
  end

  always_comb begin : select_result
    case (op_i.op)
      noncomp_pkg::OP_MIN, noncomp_pkg::OP_MAX: begin
        result = minmax_res;
        nv     = any_snan;
      end
      noncomp_pkg::OP_FLE: begin
        result = {31'b0, ~any_nan & (op_lt | op_eq)};
        nv     = any_nan;  // Signalling compare
      end
      noncomp_pkg::OP_FLT: begin
        result = {31'b0, ~any_nan & op_lt};
        nv     = any_nan;
      end
      noncomp_pkg::OP_FEQ: begin
        result = {31'b0, ~any_nan & op_eq};
        nv     = any_snan; // Quiet compare
      end
      default: begin
        result = sgnj_res;
        nv     = 1'b0;
      end
    endcase
  end

  always_comb begin : build_res
    res_d           = '0;
    res_d.result    = result;
    res_d.status.nv = nv;
    res_d.mask      = mask_i;
  end

  stage_pipe #(
    .NumPipeRegs ( NumPipeRegs             ),
    .PayloadT    ( noncomp_pkg::lane_res_t )
  ) u_res_pipe (
    .clk_i,
    .rst_i,
    .in_valid_i,
    .in_ready_o,
    .data_i      ( res_d ),
    .out_valid_o,
    .out_ready_i,
    .data_o      ( res_o ),
    .busy_o
  );

  // Narrow lanes only ever get binary16 work from the slice
  a_fmt_supported: assert property (@(posedge clk_i) disable iff (rst_i)
      in_valid_i |-> (LaneFp32 || op_i.fmt != noncomp_pkg::FMT_FP32));

endmodule

//--- hw/noncomp_pkg.sv
package noncomp_pkg;

  // --------------------------------------------------------------------------
  // Slice geometry
  // --------------------------------------------------------------------------
  localparam int unsigned SLICE_WIDTH = 64;
  localparam int unsigned NUM_LANES   = 4;  // binary16 lanes in the datapath

  typedef enum logic [0:0] {
    FMT_FP32 = 1'b0,
    FMT_FP16 = 1'b1
  } fp_fmt_e;

  typedef enum logic [2:0] {
    OP_SGNJ  = 3'd0,
    OP_SGNJN = 3'd1,
    OP_SGNJX = 3'd2,
    OP_MIN   = 3'd3,
    OP_MAX   = 3'd4,
    OP_FLE   = 3'd5,
    OP_FLT   = 3'd6,
    OP_FEQ   = 3'd7
  } op_e;

  // IEEE exception flags, in the usual fflags order
  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  typedef logic [7:0] tag_t;

  // --------------------------------------------------------------------------
  // Lane and sideband bundles
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
    op_e         op;
    fp_fmt_e     fmt;
  } lane_op_t;

  typedef struct packed {
    logic [31:0] result;
    status_t     status;
    logic        mask;   // SIMD mask bit, qualifies the status
  } lane_res_t;

  // Travels beside lane 0
  typedef struct packed {
    fp_fmt_e fmt;
    logic    vectorial;
    logic    is_cmp;
    tag_t    tag;
  } aux_t;

  function automatic int unsigned fp_width(fp_fmt_e fmt);
    return (fmt == FMT_FP32) ? 32 : 16;
  endfunction

  function automatic int unsigned num_lanes(fp_fmt_e fmt);
    return SLICE_WIDTH / fp_width(fmt);
  endfunction

endpackage

//--- hw/noncomp_slice.sv
`timescale 1ns/10ps

module noncomp_slice #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic [noncomp_pkg::SLICE_WIDTH-1:0]   operands_a_i,
  input  logic [noncomp_pkg::SLICE_WIDTH-1:0]   operands_b_i,
  input  noncomp_pkg::op_e                      op_i,
  input  noncomp_pkg::fp_fmt_e                  fmt_i,
  input  logic                                  vectorial_op_i,
  input  noncomp_pkg::tag_t                     tag_i,
  input  logic [noncomp_pkg::NUM_LANES-1:0]     simd_mask_i,
  input  logic                                  in_valid_i,
  output logic                                  in_ready_o,
  output logic [noncomp_pkg::SLICE_WIDTH-1:0]   result_o,
  output noncomp_pkg::status_t                  status_o,
  output logic                                  extension_bit_o,
  output noncomp_pkg::tag_t                     tag_o,
  output logic                                  out_valid_o,
  input  logic                                  out_ready_i,
  output logic                                  busy_o
);

  noncomp_pkg::lane_op_t  [noncomp_pkg::NUM_LANES-1:0] lane_op;
  noncomp_pkg::lane_res_t [noncomp_pkg::NUM_LANES-1:0] lane_res;
  logic [noncomp_pkg::NUM_LANES-1:0] lane_in_ready;
  logic [noncomp_pkg::NUM_LANES-1:0] lane_out_valid;  // Gated by the vector flag
  logic [noncomp_pkg::NUM_LANES-1:0] lane_busy;
  noncomp_pkg::aux_t aux_d, aux_q;
  logic              aux_in_ready, aux_busy;

  // --------------------------------------------------------------------------
  // Input side
  // --------------------------------------------------------------------------
  assign aux_d.fmt       = fmt_i;
  assign aux_d.vectorial = vectorial_op_i;
  assign aux_d.is_cmp    = op_i inside {noncomp_pkg::OP_FLE, noncomp_pkg::OP_FLT,
                                        noncomp_pkg::OP_FEQ};
  assign aux_d.tag       = tag_i;

  assign in_ready_o = lane_in_ready[0] & aux_in_ready;  // Lane 0 leads

  // Lane l sees its own element, upper bits are dropped in the lane
  always_comb begin : slice_operands
    for (int l = 0; l < int'(noncomp_pkg::NUM_LANES); l++) begin
      lane_op[l].a   = 32'(operands_a_i >> (l * noncomp_pkg::fp_width(fmt_i)));
      lane_op[l].b   = 32'(operands_b_i >> (l * noncomp_pkg::fp_width(fmt_i)));
      lane_op[l].op  = op_i;
      lane_op[l].fmt = fmt_i;
    end
  end

  for (genvar l = 0; l < noncomp_pkg::NUM_LANES; l++) begin : gen_lanes
    logic in_valid, out_valid, out_ready;

    assign in_valid = in_valid_i &
        ((l == 0) | (vectorial_op_i & (l < noncomp_pkg::num_lanes(fmt_i))));
    assign out_ready          = out_ready_i & ((l == 0) | aux_q.vectorial);
    assign lane_out_valid[l]  = out_valid & ((l == 0) | aux_q.vectorial);

    noncomp_lane #(
      .NumPipeRegs ( NumPipeRegs ),
      .LaneFp32    ( l < noncomp_pkg::num_lanes(noncomp_pkg::FMT_FP32) )
    ) u_lane (
      .clk_i,
      .rst_i,
      .op_i        ( lane_op[l]       ),
      .mask_i      ( simd_mask_i[l]   ),
      .in_valid_i  ( in_valid         ),
      .in_ready_o  ( lane_in_ready[l] ),
      .res_o       ( lane_res[l]      ),
      .out_valid_o ( out_valid        ),
      .out_ready_i ( out_ready        ),
      .busy_o      ( lane_busy[l]     )
    );

    if (l > 0) begin : gen_room_check
      // Upper lanes never hold more than lane 0, so they always have room
      a_lane_room: assert property (@(posedge clk_i) disable iff (rst_i)
          in_valid && in_ready_o |-> lane_in_ready[l]);
    end
  end

  stage_pipe #(
    .NumPipeRegs ( NumPipeRegs        ),
    .PayloadT    ( noncomp_pkg::aux_t )
  ) u_aux_pipe (
    .clk_i,
    .rst_i,
    .in_valid_i,
    .in_ready_o  ( aux_in_ready  ),
    .data_i      ( aux_d         ),
    .out_valid_o (               ),
    .out_ready_i,
    .data_o      ( aux_q         ),
    .busy_o      ( aux_busy      )
  );

  // --------------------------------------------------------------------------
  // Output side
  // --------------------------------------------------------------------------
  result_pack u_result_pack (
    .lane_res_i      ( lane_res       ),
    .aux_i           ( aux_q          ),
    .lane_valid_i    ( lane_out_valid ),
    .result_o,
    .status_o,
    .extension_bit_o
  );

  assign out_valid_o = lane_out_valid[0];
  assign tag_o       = aux_q.tag;
  assign busy_o      = (|lane_busy) | aux_busy;

endmodule

//--- hw/result_pack.sv
`timescale 1ns/10ps

module result_pack (
  input  noncomp_pkg::lane_res_t [noncomp_pkg::NUM_LANES-1:0] lane_res_i,
  input  noncomp_pkg::aux_t                                   aux_i,
  input  logic [noncomp_pkg::NUM_LANES-1:0]                   lane_valid_i,
  output logic [noncomp_pkg::SLICE_WIDTH-1:0]                 result_o,
  output noncomp_pkg::status_t                                status_o,
  output logic                                                extension_bit_o
);

  localparam int unsigned LANES_FP32 = noncomp_pkg::num_lanes(noncomp_pkg::FMT_FP32);
  localparam int unsigned LANES_FP16 = noncomp_pkg::num_lanes(noncomp_pkg::FMT_FP16);

  logic ext_bit;

  // NaN-box FP results, zero-extend compares
  assign ext_bit         = ~aux_i.is_cmp;
  assign extension_bit_o = ext_bit;

  // --------------------------------------------------------------------------
  // Result assembly
  // --------------------------------------------------------------------------
  always_comb begin : pack_result
    result_o = {noncomp_pkg::SLICE_WIDTH{ext_bit}};  // Unused lanes take the ext bit
    if (aux_i.fmt == noncomp_pkg::FMT_FP32) begin
      for (int l = 0; l < int'(LANES_FP32); l++) begin
        if (lane_valid_i[l]) begin
          result_o[32*l +: 32] = lane_res_i[l].result;
        end
      end
    end else begin
      for (int l = 0; l < int'(LANES_FP16); l++) begin
        if (lane_valid_i[l]) begin
          result_o[16*l +: 16] = lane_res_i[l].result[15:0];
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Status collapse
  // --------------------------------------------------------------------------
  always_comb begin : collapse_status
    status_o = '0;
    for (int l = 0; l < int'(noncomp_pkg::NUM_LANES); l++) begin
      if (lane_valid_i[l] && lane_res_i[l].mask) begin
        status_o |= lane_res_i[l].status;
      end
    end
  end

  // Compare lanes carry a single result bit
  always_comb begin : cmp_check
    for (int l = 0; l < int'(noncomp_pkg::NUM_LANES); l++) begin
      if (aux_i.is_cmp && lane_valid_i[l]) begin
        assert (lane_res_i[l].result[31:1] == '0)
          else $error("compare result in lane %0d has upper bits set", l);
      end
    end
  end

endmodule

//--- hw/stage_pipe.sv
`timescale 1ns/10ps

module stage_pipe #(
  parameter int unsigned NumPipeRegs = 2,
  parameter type         PayloadT    = logic
) (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    in_valid_i,
  output logic    in_ready_o,
  input  PayloadT data_i,
  output logic    out_valid_o,
  input  logic    out_ready_i,
  output PayloadT data_o,
  output logic    busy_o
);

  // Index i is the value after i register stages
  PayloadT pipe_data  [0:NumPipeRegs];
  logic    pipe_valid [0:NumPipeRegs];
  logic    pipe_ready [0:NumPipeRegs];

  assign pipe_data[0]  = data_i;
  assign pipe_valid[0] = in_valid_i;

  // Ready runs backwards, a stage moves when the next one takes or is empty
  always_comb begin : ready_chain
    pipe_ready[NumPipeRegs] = out_ready_i;
    for (int i = int'(NumPipeRegs) - 1; i >= 0; i--) begin
      pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid[i+1];
    end
  end

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    logic    valid_q;
    PayloadT data_q;
    logic    load;

    assign load = pipe_ready[i] & pipe_valid[i];  // Valid item advances

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        valid_q <= 1'b0;
      end else if (pipe_ready[i]) begin
        valid_q <= pipe_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (load) begin
        data_q <= pipe_data[i];
      end
    end

    assign pipe_valid[i+1] = valid_q;
    assign pipe_data[i+1]  = data_q;
  end

  assign in_ready_o  = pipe_ready[0];
  assign out_valid_o = pipe_valid[NumPipeRegs];
  assign data_o      = pipe_data[NumPipeRegs];

  always_comb begin : busy_flag
    busy_o = 1'b0;
    for (int i = 1; i <= int'(NumPipeRegs); i++) begin
      busy_o |= pipe_valid[i];
    end
  end

  if (NumPipeRegs > 0) begin : gen_hold_check
    // A stalled output item stays put until taken
    a_hold_stall: assert property (@(posedge clk_i) disable iff (rst_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(data_o));
  end

endmodule

//--- noncomp_slice.f
+incdir+test
hw/noncomp_pkg.sv
hw/stage_pipe.sv
hw/noncomp_lane.sv
hw/result_pack.sv
hw/noncomp_slice.sv
test/tb_noncomp_slice.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_noncomp_slice -f noncomp_slice.f \
  --Mdir obj_dir -o sim_noncomp

# A $fatal gives a non-zero exit, so the log decides the outcome
./obj_dir/sim_noncomp > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
  echo "Simulation failed, see $LOG"
  exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
  echo "Simulation ended without a result, see $LOG"
  exit 1
fi
echo "Simulation passed"

//--- test/tb_noncomp_model.svh
`ifndef TB_NONCOMP_MODEL_SVH
`define TB_NONCOMP_MODEL_SVH

// Element sits in the low bits of x
function automatic bit nan_in(input logic [31:0] x, input noncomp_pkg::fp_fmt_e fmt);
  if (fmt == noncomp_pkg::FMT_FP32) begin
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  end
  return (x[14:10] == 5'h1f) && (x[9:0] != 10'd0);
endfunction

function automatic bit snan_in(input logic [31:0] x, input noncomp_pkg::fp_fmt_e fmt);
  bit quiet;
  quiet = (fmt == noncomp_pkg::FMT_FP32) ? x[22] : x[9];
  return nan_in(x, fmt) && !quiet;
endfunction

// Signed integer with the order of the non-NaN values, both zeros give 0
function automatic longint order_key(input logic [31:0] x, input noncomp_pkg::fp_fmt_e fmt);
  longint mag;
  bit     neg;
  mag = (fmt == noncomp_pkg::FMT_FP32) ? longint'(x[30:0]) : longint'(x[14:0]);
  neg = (fmt == noncomp_pkg::FMT_FP32) ? x[31] : x[15];
  return neg ? -mag : mag;
endfunction

function automatic logic [31:0] lane_model(input noncomp_pkg::op_e op,
    input noncomp_pkg::fp_fmt_e fmt, input logic [31:0] a_in, input logic [31:0] b_in,
    output bit nv);
  int          w;
  logic [31:0] a, b, res;
  bit          sa, sb, na, nb, any_nan;
  longint      ka, kb;
  w       = (fmt == noncomp_pkg::FMT_FP32) ? 32 : 16;
  a       = (w == 32) ? a_in : {16'h0, a_in[15:0]};
  b       = (w == 32) ? b_in : {16'h0, b_in[15:0]};
  sa      = a[w-1];
  sb      = b[w-1];
  na      = nan_in(a, fmt);
  nb      = nan_in(b, fmt);
  any_nan = na || nb;
  ka      = order_key(a, fmt);
  kb      = order_key(b, fmt);
  res     = a;
  nv      = 1'b0;
  case (op)
    noncomp_pkg::OP_SGNJ:  res[w-1] = sb;
    noncomp_pkg::OP_SGNJN: res[w-1] = !sb;
    noncomp_pkg::OP_SGNJX: res[w-1] = sa ^ sb;
    noncomp_pkg::OP_MIN, noncomp_pkg::OP_MAX: begin
      nv = snan_in(a, fmt) || snan_in(b, fmt);
      if (na && nb) begin
        res = (w == 32) ? 32'h7fc0_0000 : 32'h0000_7e00;
      end else if (na) begin
        res = b;
      end else if (nb) begin
        res = a;
      end else if (ka == kb) begin
        res = ((op == noncomp_pkg::OP_MIN) == sa) ? a : b;  // -0 below +0
      end else begin
        res = ((ka < kb) == (op == noncomp_pkg::OP_MIN)) ? a : b;
      end
    end
    noncomp_pkg::OP_FLE: begin
      nv  = any_nan;
      res = {31'b0, !any_nan && (ka <= kb)};
    end
    noncomp_pkg::OP_FLT: begin
      nv  = any_nan;
      res = {31'b0, !any_nan && (ka < kb)};
    end
    default: begin
      nv  = snan_in(a, fmt) || snan_in(b, fmt);  // FEQ is quiet
      res = {31'b0, !any_nan && (ka == kb)};
    end
  endcase
  return res;
endfunction

// Full 64-bit response of the slice, with the masked NV collapse
function automatic logic [noncomp_pkg::SLICE_WIDTH-1:0] expected_slice(
    input noncomp_pkg::op_e op, input noncomp_pkg::fp_fmt_e fmt, input logic vec,
    input logic [63:0] a, input logic [63:0] b, input logic [3:0] mask,
    output noncomp_pkg::status_t st, output logic ext);
  logic [63:0] res;
  logic [31:0] elem;
  int          w, lanes;
  bit          nv;
  w     = (fmt == noncomp_pkg::FMT_FP32) ? 32 : 16;
  lanes = vec ? (64 / w) : 1;
  ext   = !(op inside {noncomp_pkg::OP_FLE, noncomp_pkg::OP_FLT, noncomp_pkg::OP_FEQ});
  res   = {64{ext}};
  st    = '0;
  for (int l = 0; l < lanes; l++) begin
    elem = lane_model(op, fmt, 32'(a >> (l * w)), 32'(b >> (l * w)), nv);
    if (w == 32) begin
      res[32*l +: 32] = elem;
    end else begin
      res[16*l +: 16] = elem[15:0];
    end
    if (mask[l]) begin
      st.nv = st.nv | nv;
    end
  end
  return res;
endfunction

`endif

//--- test/tb_noncomp_slice.sv
`timescale 1ns/10ps

module tb_noncomp_slice;

  logic                         clk_i, rst_i;
  logic [63:0]                  operands_a_i, operands_b_i, result_o;
  noncomp_pkg::op_e             op_i;
  noncomp_pkg::fp_fmt_e         fmt_i;
  logic                         vectorial_op_i, in_valid_i, in_ready_o;
  noncomp_pkg::tag_t            tag_i, tag_o;
  logic [3:0]                   simd_mask_i;
  noncomp_pkg::status_t         status_o;
  logic                         extension_bit_o, out_valid_o, out_ready_i, busy_o;

  logic [31:0]       rng_state   = 32'h9296_f262;
  noncomp_pkg::tag_t next_tag    = 8'h01;

  `include "tb_noncomp_model.svh"

  noncomp_slice #(.NumPipeRegs(2)) uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Random values and checks
  // --------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic logic [15:0] rand_fp16();
    logic [31:0] r;
    r = xorshift32();
    case (r[19:16])
      4'd0:    return 16'h7d55;  // Signalling NaN
      4'd1:    return 16'hfe00;  // Quiet NaN
      4'd2:    return 16'h0000;
      4'd3:    return 16'h8000;
      default: return r[15:0];
    endcase
  endfunction

  function automatic logic [31:0] rand_fp32();
    logic [31:0] r;
    r = xorshift32();
    case (r[3:0])
      4'd0:    return 32'h7f80_0001;  // Signalling NaN
      4'd1:    return 32'h7fc0_0000;
      4'd2:    return 32'h0000_0000;
      4'd3:    return 32'h8000_0000;
      default: return r;
    endcase
  endfunction

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_result(input logic [noncomp_pkg::SLICE_WIDTH-1:0] got,
      input logic [noncomp_pkg::SLICE_WIDTH-1:0] exp, input string name);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_status(input noncomp_pkg::status_t got, input noncomp_pkg::status_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: status_o = %b, expected %b", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_tag(input noncomp_pkg::tag_t got, input noncomp_pkg::tag_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: tag_o = %h, expected %h", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // --------------------------------------------------------------------------
  // Handshake helpers
  // --------------------------------------------------------------------------
  task automatic drive_op(input noncomp_pkg::op_e op, input noncomp_pkg::fp_fmt_e fmt,
      input logic vec, input logic [63:0] a, input logic [63:0] b, input logic [3:0] mask,
      input noncomp_pkg::tag_t tag);
    op_i           = op;
    fmt_i          = fmt;
    vectorial_op_i = vec;
    operands_a_i   = a;
    operands_b_i   = b;
    simd_mask_i    = mask;
    tag_i          = tag;
    in_valid_i     = 1'b1;
  endtask

  task automatic send_op(input noncomp_pkg::op_e op, input noncomp_pkg::fp_fmt_e fmt,
      input logic vec, input logic [63:0] a, input logic [63:0] b, input logic [3:0] mask,
      input noncomp_pkg::tag_t tag);
    int   cycles;
    logic taken;
    cycles = 0;
    taken  = 1'b0;
    drive_op(op, fmt, vec, a, b, mask, tag);
    while (!taken) begin
      #1;                // Ready settles after the falling-edge drive
      taken = in_ready_o;
      @(negedge clk_i);  // Item is taken at the rising edge in between
      cycles++;
      if (!taken && cycles > 100) begin
        $display("Timeout: in_ready_o stayed low for 100 cycles");
        abort_run();
      end
    end
    in_valid_i = 1'b0;
  endtask

  task automatic receive_and_check(input logic [63:0] exp_res,
      input noncomp_pkg::status_t exp_st, input logic exp_ext, input noncomp_pkg::tag_t exp_tag);
    int cycles;
    cycles = 0;
    while (!out_valid_o) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 100) begin
        $display("Timeout: out_valid_o did not rise within 100 cycles");
        abort_run();
      end
    end
    check_result(result_o, exp_res, "result_o");
    check_status(status_o, exp_st);
    check_flag(extension_bit_o, exp_ext, "extension_bit_o");
    check_tag(tag_o, exp_tag);
    @(negedge clk_i);  // Taken at the edge in between
  endtask

  task automatic run_op(input noncomp_pkg::op_e op, input noncomp_pkg::fp_fmt_e fmt,
      input logic vec, input logic [63:0] a, input logic [63:0] b, input logic [3:0] mask);
    logic [63:0]          exp_res;
    noncomp_pkg::status_t exp_st;
    logic                 exp_ext;
    noncomp_pkg::tag_t    tag;
    tag      = next_tag;
    next_tag = next_tag + 8'd1;
    exp_res  = expected_slice(op, fmt, vec, a, b, mask, exp_st, exp_ext);
    send_op(op, fmt, vec, a, b, mask, tag);
    receive_and_check(exp_res, exp_st, exp_ext, tag);
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic reset_and_sign_inject();
    check_flag(out_valid_o, 1'b0, "out_valid_o");
    check_flag(busy_o, 1'b0, "busy_o");
    check_flag(in_ready_o, 1'b1, "in_ready_o");
    for (int k = 0; k < 24; k++) begin
      run_op(noncomp_pkg::op_e'(k % 3), noncomp_pkg::FMT_FP32, 1'b0,
             {xorshift32(), rand_fp32()}, {xorshift32(), rand_fp32()}, 4'hf);
    end
  endtask

  task automatic vector_min_max();
    logic [63:0] a, b;
    logic [31:0] r;
    for (int k = 0; k < 40; k++) begin
      for (int l = 0; l < 4; l++) begin
        a[16*l +: 16] = rand_fp16();
        b[16*l +: 16] = rand_fp16();
      end
      r = xorshift32();
      run_op((k % 2 == 0) ? noncomp_pkg::OP_MIN : noncomp_pkg::OP_MAX,
             noncomp_pkg::FMT_FP16, 1'b1, a, b, r[3:0]);
    end
  endtask

  task automatic vector_compare();
    logic [63:0] a, b;
    logic [31:0] r;
    for (int k = 0; k < 36; k++) begin
      for (int l = 0; l < 2; l++) begin
        r             = xorshift32();
        a[32*l +: 32] = rand_fp32();
        b[32*l +: 32] = r[4] ? a[32*l +: 32] : rand_fp32();  // Often equal
      end
      run_op(noncomp_pkg::op_e'(5 + k % 3), noncomp_pkg::FMT_FP32, 1'b1, a, b, 4'b1111);
      run_op(noncomp_pkg::op_e'(5 + k % 3), noncomp_pkg::FMT_FP32, 1'b1, a, b, 4'b1101);
    end
    // Signalling NaN only in lane 1
    a = {32'h3f80_0000, 32'h4000_0000};
    b = {32'h7f80_0001, 32'h4000_0000};
    run_op(noncomp_pkg::OP_FEQ, noncomp_pkg::FMT_FP32, 1'b1, a, b, 4'b1111);
    run_op(noncomp_pkg::OP_FEQ, noncomp_pkg::FMT_FP32, 1'b1, a, b, 4'b1101);
  endtask

  task automatic scalar_half_packing();
    run_op(noncomp_pkg::OP_FLT, noncomp_pkg::FMT_FP16, 1'b0,
           {xorshift32(), 32'h1234_3c00}, {xorshift32(), 32'h5678_4000}, 4'hf);
    for (int k = 0; k < 16; k++) begin
      run_op(noncomp_pkg::op_e'(k % 8), noncomp_pkg::FMT_FP16, 1'b0,
             {xorshift32(), xorshift32()}, {xorshift32(), xorshift32()}, 4'hf);
    end
  endtask

  task automatic back_pressure_order();
    noncomp_pkg::op_e     ops   [4] = '{noncomp_pkg::OP_MAX, noncomp_pkg::OP_FLT,
                                        noncomp_pkg::OP_SGNJX, noncomp_pkg::OP_FEQ};
    noncomp_pkg::fp_fmt_e fmts  [4] = '{noncomp_pkg::FMT_FP16, noncomp_pkg::FMT_FP32,
                                        noncomp_pkg::FMT_FP32, noncomp_pkg::FMT_FP16};
    logic                 vecs  [4] = '{1'b1, 1'b1, 1'b0, 1'b1};
    logic [63:0]          a [4], b [4], exp_res [4], held_res;
    logic [3:0]           mask [4];
    noncomp_pkg::status_t exp_st [4];
    logic                 exp_ext [4];
    noncomp_pkg::tag_t    tags [4];
    logic [31:0]          r;
    for (int i = 0; i < 4; i++) begin
      r          = xorshift32();
      a[i]       = {rand_fp32(), rand_fp16(), rand_fp16()};
      b[i]       = {rand_fp32(), rand_fp16(), rand_fp16()};
      mask[i]    = r[3:0];
      tags[i]    = next_tag;
      next_tag   = next_tag + 8'd1;
      exp_res[i] = expected_slice(ops[i], fmts[i], vecs[i], a[i], b[i], mask[i],
                                  exp_st[i], exp_ext[i]);
    end
    out_ready_i = 1'b0;
    send_op(ops[0], fmts[0], vecs[0], a[0], b[0], mask[0], tags[0]);
    send_op(ops[1], fmts[1], vecs[1], a[1], b[1], mask[1], tags[1]);
    drive_op(ops[2], fmts[2], vecs[2], a[2], b[2], mask[2], tags[2]);
    held_res = result_o;
    check_result(held_res, exp_res[0], "result_o");
    repeat (4) begin  // Full pipe, stalled output
      check_flag(in_ready_o, 1'b0, "in_ready_o");
      check_flag(out_valid_o, 1'b1, "out_valid_o");
      check_flag(busy_o, 1'b1, "busy_o");
      check_result(result_o, held_res, "result_o");
      check_status(status_o, exp_st[0]);
      check_tag(tag_o, tags[0]);
      @(negedge clk_i);
    end
    out_ready_i = 1'b1;
    fork
      begin
        send_op(ops[2], fmts[2], vecs[2], a[2], b[2], mask[2], tags[2]);
        send_op(ops[3], fmts[3], vecs[3], a[3], b[3], mask[3], tags[3]);
      end
      begin
        for (int i = 0; i < 4; i++) begin
          receive_and_check(exp_res[i], exp_st[i], exp_ext[i], tags[i]);
        end
      end
    join
    check_flag(busy_o, 1'b0, "busy_o");
  endtask

  initial begin
    rst_i          = 1'b1;
    in_valid_i     = 1'b0;
    out_ready_i    = 1'b1;
    operands_a_i   = '0;
    operands_b_i   = '0;
    op_i           = noncomp_pkg::OP_SGNJ;
    fmt_i          = noncomp_pkg::FMT_FP32;
    vectorial_op_i = 1'b0;
    tag_i          = '0;
    simd_mask_i    = '1;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    reset_and_sign_inject();
    vector_min_max();
    vector_compare();
    scalar_half_packing();
    back_pressure_order();

    $display("Result: PASSED");
    $finish;
  end

endmodule
